// ==== design/execPkg.sv ====
// Execute stage definitions
package execPkg;

   // Word and register index widths are fixed by the ISA
   localparam int dataW    = 16;
   localparam int regAddrW = 3;

   typedef logic [dataW-1:0]    dataT;
   typedef logic [regAddrW-1:0] regAddrT;
   typedef logic [4:0]          opcodeT;

   // NOP encoding, inserted on squash and after reset
   localparam dataT nopInstr = 16'h0800;

   //////////////////////////////////////////////////////////////////////
   // Opcodes the execute stage looks at
   //////////////////////////////////////////////////////////////////////
   localparam opcodeT opJ      = 5'b00100;
   localparam opcodeT opJr     = 5'b00101;
   localparam opcodeT opJal    = 5'b00110;
   localparam opcodeT opJalr   = 5'b00111;
   localparam opcodeT opXori   = 5'b01010;
   localparam opcodeT opAndni  = 5'b01011;
   localparam opcodeT opSt     = 5'b10000;
   localparam opcodeT opSlbi   = 5'b10010;
   localparam opcodeT opStu    = 5'b10011;
   localparam opcodeT opLbi    = 5'b11000;
   localparam opcodeT opBtr    = 5'b11001;
   localparam opcodeT opRShift = 5'b11010;
   localparam opcodeT opRArith = 5'b11011;
   localparam opcodeT opSeq    = 5'b11100;
   localparam opcodeT opSlt    = 5'b11101;
   localparam opcodeT opSle    = 5'b11110;
   localparam opcodeT opSco    = 5'b11111;

   // Shifts and rotates in the low half, add and logic in the high half
   typedef enum logic [2:0] {
      rolOp, sllOp, rorOp, srlOp, addOp, andOp, orOp, xorOp
   } aluOpT;

   // Top bit marks a conditional branch, low bits follow the opcode
   typedef enum logic [2:0] {
      brNone = 3'b000,
      brEqz  = 3'b100,
      brNez  = 3'b101,
      brLtz  = 3'b110,
      brGez  = 3'b111
   } brTypeT;

   typedef enum logic [1:0] {srcRt, srcImm5, srcImm8, srcSlbi} bSrcT;

   typedef enum logic [1:0] {fwdNone = 2'b00, fwdWb = 2'b01, fwdEx = 2'b10} fwdSelT;

   // EX/MEM pipeline payload
   typedef struct packed {
      dataT instr;
      dataT result;
      dataT incrPc;
      dataT bOut;
      dataT storeData;
      dataT rtData;
      logic regWrt;
      logic unaligned;
   } exMemT;

endpackage

// ==== design/execCtrlIf.sv ====
// Execute control bundle
`timescale 1ns/1ps

interface execCtrlIf;
   import execPkg::*;

   // ALU operation and operand conditioning
   aluOpT  aluOp;
   logic   invA;
   logic   invB;
   logic   cin;
   // Overflow flavour, signed or carry out
   logic   signedOp;
   // Immediate handling and B source
   logic   zeroExt;
   bSrcT   bSrc;
   // Control flow
   brTypeT brType;
   logic   jumpReg;

   // Decode side drives every control
   modport decode (
      output aluOp, invA, invB, cin, signedOp, zeroExt, bSrc, brType, jumpReg
   );

   // Operand select, ALU and result logic only read
   modport sink (
      input aluOp, invA, invB, cin, signedOp, zeroExt, bSrc, brType, jumpReg
   );

endinterface

// ==== design/execDecode.sv ====
// Execute control decode
`timescale 1ns/1ps

module execDecode (
   input  execPkg::dataT instr,
   execCtrlIf.decode     ctrl,
   output logic          rsValid,
   output logic          rtValid
);
   import execPkg::*;

   opcodeT     opcode;
   logic [1:0] arithF;

   assign opcode = instr[15:11];

   // R-format takes its function from the low bits and immediates from the opcode
   assign arithF = ((opcode == opRArith) || (opcode == opRShift)) ? instr[1:0] : opcode[1:0];

   //////////////////////////////////////////////////////////////////////
   // ALU and operand controls
   //////////////////////////////////////////////////////////////////////
   always_comb begin
      ctrl.aluOp    = addOp;
      ctrl.invA     = 1'b0;
      ctrl.invB     = 1'b0;
      ctrl.bSrc     = srcImm8;
      ctrl.brType   = brNone;
      // Only SCO wants the carry out instead of signed overflow
      ctrl.signedOp = (opcode != opSco);
      ctrl.zeroExt  = (opcode == opXori) || (opcode == opAndni);
      ctrl.jumpReg  = (opcode == opJr) || (opcode == opJalr);
      casez (opcode)
         // ADD SUB XOR ANDN and their immediate forms
         opRArith, 5'b010??: begin
            ctrl.bSrc = (opcode == opRArith) ? srcRt : srcImm5;
            case (arithF)
               2'b01:   ctrl.invA  = 1'b1;
               2'b10:   ctrl.aluOp = xorOp;
               2'b11: begin
                  ctrl.aluOp = andOp;
                  ctrl.invB  = 1'b1;
               end
               default: ctrl.aluOp = addOp;
            endcase
         end
         // Shifts and rotates, register or immediate amount
         opRShift, 5'b101??: begin
            ctrl.bSrc  = (opcode == opRShift) ? srcRt : srcImm5;
            ctrl.aluOp = aluOpT'({1'b0, arithF});
         end
         5'b011??: ctrl.brType = brTypeT'({1'b1, opcode[1:0]});
         // SEQ SLT SLE compute Rs minus Rt, SCO a plain add
         5'b111??: begin
            ctrl.bSrc = srcRt;
            ctrl.invB = (opcode != opSco);
         end
         opBtr:    ctrl.bSrc = srcRt;
         opSlbi:   ctrl.bSrc = srcSlbi;
         // Loads and stores add a 5-bit offset
         5'b100??: ctrl.bSrc = srcImm5;
         default:  ctrl.bSrc = srcImm8;
      endcase
      // Two's complement needs the extra one for either inversion
      ctrl.cin = ctrl.invA | ctrl.invB;
   end

   //////////////////////////////////////////////////////////////////////
   // Source register usage for the hazard unit
   //////////////////////////////////////////////////////////////////////
   // No Rs for HALT NOP J JAL and LBI
   assign rsValid = (opcode[4:2] != 3'b000) && (opcode != opJ) && (opcode != opJal)
                    && (opcode != opLbi);
   // Rt read by R-format, set-condition and store data
   assign rtValid = (opcode[4:1] == 4'b1101) || (opcode[4:2] == 3'b111)
                    || (opcode == opSt) || (opcode == opStu);

endmodule

// ==== design/operandSelect.sv ====
// Operand forwarding and B mux
`timescale 1ns/1ps

module operandSelect (
   execCtrlIf.sink         ctrl,
   input  execPkg::dataT   instr,
   input  execPkg::dataT   regA,
   input  execPkg::dataT   regB,
   input  execPkg::dataT   wData,
   input  execPkg::dataT   exResult,
   input  execPkg::fwdSelT fwdA,
   input  execPkg::fwdSelT fwdB,
   output execPkg::dataT   aSel,
   output execPkg::dataT   bSel,
   output execPkg::dataT   rtSel,
   output execPkg::dataT   ext8,
   output execPkg::dataT   ext11
);
   import execPkg::*;

   opcodeT opcode;
   dataT   aFwd;
   dataT   ext5;
   dataT   slbiVal;
   logic   bZero;

   // Writeback data on 01, EX/MEM result on 10
   function automatic dataT fwdMux(input fwdSelT sel, input dataT regVal,
                                   input dataT wbVal, input dataT exVal);
      case (sel)
         fwdWb:   return wbVal;
         fwdEx:   return exVal;
         fwdNone: return regVal;
         default: return regVal;
      endcase
   endfunction

   assign opcode = instr[15:11];
   assign aFwd   = fwdMux(fwdA, regA, wData, exResult);
   assign rtSel  = fwdMux(fwdB, regB, wData, exResult);

   // XORI and ANDNI zero extend, everything else sign extends
   assign ext5  = ctrl.zeroExt ? {11'h000, instr[4:0]} : {{11{instr[4]}}, instr[4:0]};
   assign ext8  = ctrl.zeroExt ? {8'h00, instr[7:0]} : {{8{instr[7]}}, instr[7:0]};
   assign ext11 = {{5{instr[10]}}, instr[10:0]};

   // SLBI shifts the old low byte up under the new immediate byte
   assign slbiVal = {aFwd[7:0], instr[7:0]};

   // LBI and SLBI pass B straight through the adder
   assign aSel = ((opcode == opLbi) || (opcode == opSlbi)) ? '0 : aFwd;

   // Branches test Rs alone and BTR reverses Rs
   assign bZero = (ctrl.brType != brNone) || (opcode == opBtr);

   always_comb begin
      if (bZero) begin
         bSel = '0;
      end else begin
         case (ctrl.bSrc)
            srcImm5: bSel = ext5;
            srcImm8: bSel = ext8;
            srcSlbi: bSel = slbiVal;
            default: bSel = rtSel;
         endcase
      end
   end

endmodule

// ==== design/execAlu.sv ====
// Execute ALU
`timescale 1ns/1ps

module execAlu (
   execCtrlIf.sink       ctrl,
   input  execPkg::dataT a,
   input  execPkg::dataT b,
   output execPkg::dataT y,
   output logic          zf,
   output logic          ofl
);
   import execPkg::*;

   dataT               aIn;
   dataT               bIn;
   dataT               sum;
   logic               carry;
   logic [3:0]         sh;
   logic [2*dataW-1:0] rolCat;
   logic [2*dataW-1:0] rorCat;

   // Operand conditioning for subtract and ANDN
   assign aIn = ctrl.invA ? ~a : a;
   assign bIn = ctrl.invB ? ~b : b;

   // Shift amount is the low nibble of B
   assign sh = b[3:0];

   //////////////////////////////////////////////////////////////////////
   // Adder with carry in
   //////////////////////////////////////////////////////////////////////
   assign {carry, sum} = {1'b0, aIn} + {1'b0, bIn} + {{dataW{1'b0}}, ctrl.cin};

   // Rotates from a doubled copy of A
   assign rolCat = {aIn, aIn} << sh;
   assign rorCat = {aIn, aIn} >> sh;

   always_comb begin
      case (ctrl.aluOp)
         rolOp:   y = rolCat[2*dataW-1:dataW];
         sllOp:   y = aIn << sh;
         rorOp:   y = rorCat[dataW-1:0];
         srlOp:   y = aIn >> sh;
         andOp:   y = aIn & bIn;
         orOp:    y = aIn | bIn;
         xorOp:   y = aIn ^ bIn;
         default: y = sum;
      endcase
   end

   //////////////////////////////////////////////////////////////////////
   // Flags
   //////////////////////////////////////////////////////////////////////
   assign zf = (y == '0);

   // Signed overflow when both inputs agree in sign and the sum does not
   // Carry out serves SCO
   assign ofl = ctrl.signedOp ?
                ((aIn[dataW-1] == bIn[dataW-1]) && (sum[dataW-1] != aIn[dataW-1])) :
                carry;

endmodule

// ==== design/resultBranch.sv ====
// Result select and branch resolve
`timescale 1ns/1ps

module resultBranch (
   execCtrlIf.sink       ctrl,
   input  execPkg::dataT instr,
   input  execPkg::dataT incrPc,
   input  execPkg::dataT aluOut,
   input  logic          zf,
   input  logic          ofl,
   input  execPkg::dataT ext8,
   input  execPkg::dataT ext11,
   output execPkg::dataT result,
   output execPkg::dataT newPc,
   output logic          pcSrc,
   output logic          squash
);
   import execPkg::*;

   opcodeT opcode;
   dataT   revOut;
   logic   sf;
   logic   sltBit;
   logic   taken;
   logic   jumpImm;

   assign opcode = instr[15:11];
   assign sf     = aluOut[dataW-1];

   // Sign of Rs minus Rt, corrected when the subtract overflowed
   assign sltBit = sf ^ ofl;

   // BTR mirror of the ALU output
   always_comb begin
      for (int i = 0; i < dataW; i++) begin
         revOut[i] = aluOut[dataW-1-i];
      end
   end

   always_comb begin
      case (opcode)
         opSeq:   result = {{(dataW-1){1'b0}}, zf};
         opSlt:   result = {{(dataW-1){1'b0}}, sltBit};
         opSle:   result = {{(dataW-1){1'b0}}, sltBit | zf};
         opSco:   result = {{(dataW-1){1'b0}}, ofl};
         opBtr:   result = revOut;
         default: result = aluOut;
      endcase
   end

   //////////////////////////////////////////////////////////////////////
   // Branch and jump resolve
   //////////////////////////////////////////////////////////////////////
   // ALU holds Rs plus zero for conditional branches
   always_comb begin
      case (ctrl.brType)
         brEqz:   taken = zf;
         brNez:   taken = !zf;
         brLtz:   taken = sf;
         brGez:   taken = !sf;
         default: taken = 1'b0;
      endcase
   end

   assign jumpImm = (opcode == opJ) || (opcode == opJal);

   always_comb begin
      if (ctrl.jumpReg) begin
         newPc = aluOut;
      end else if (jumpImm) begin
         newPc = incrPc + ext11;
      end else if (taken) begin
         newPc = incrPc + ext8;
      end else begin
         newPc = incrPc;
      end
   end

   assign pcSrc  = taken | jumpImm | ctrl.jumpReg;
   // J and JAL redirect without flushing the stage register
   assign squash = (newPc != incrPc) && !jumpImm;

endmodule

// ==== design/exMemReg.sv ====
// EX/MEM pipeline register
`timescale 1ns/1ps

module exMemReg (
   input  logic           clk,
   input  logic           rstN,
   input  logic           stall,
   input  logic           squash,
   input  execPkg::exMemT next,
   output execPkg::exMemT q
);
   import execPkg::*;

   //////////////////////////////////////////////////////////////////////
   // Stage register
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!rstN) begin
         // Empty stage looks like a NOP downstream
         q       <= '0;
         q.instr <= nopInstr;
      end else if (!stall) begin
         q <= next;
         // Squashed slot turns into a bubble
         if (squash) begin
            q.instr  <= nopInstr;
            q.regWrt <= 1'b0;
         end
      end
      // Memory stall holds everything
   end

   // A squashed slot never reaches writeback with a write enable
   squashNoWrite: assert property (
      @(posedge clk) disable iff (!rstN)
      (squash && !stall) |=> !q.regWrt
   );

   // A held slot keeps its payload until memory releases
   stallHold: assert property (
      @(posedge clk) disable iff (!rstN)
      stall |=> $stable(q)
   );

endmodule

// ==== design/executeStage.sv ====
// Execute stage top
`timescale 1ns/1ps

module executeStage (
   input  logic             clk,
   input  logic             rstN,
   input  execPkg::dataT    instrIn,
   input  execPkg::dataT    incrPcIn,
   input  execPkg::dataT    regA,
   input  execPkg::dataT    regB,
   input  execPkg::dataT    wData,
   input  execPkg::fwdSelT  fwdA,
   input  execPkg::fwdSelT  fwdB,
   input  logic             regWrtIn,
   input  logic             unalignedIn,
   input  logic             stall,
   output execPkg::dataT    instrOut,
   output execPkg::dataT    resultOut,
   output execPkg::dataT    incrPcOut,
   output execPkg::dataT    bOut,
   output execPkg::dataT    storeDataOut,
   output execPkg::dataT    rtDataOut,
   output logic             regWrtOut,
   output logic             unalignedOut,
   output execPkg::dataT    newPc,
   output logic             pcSrc,
   output logic             squash,
   output execPkg::regAddrT rsIdx,
   output execPkg::regAddrT rtIdx,
   output logic             rsValid,
   output logic             rtValid
);
   import execPkg::*;

   dataT   aSel;
   dataT   bSel;
   dataT   rtSel;
   dataT   ext8;
   dataT   ext11;
   dataT   aluOut;
   dataT   result;
   logic   zf;
   logic   ofl;
   logic   isStore;
   opcodeT opcode;
   exMemT  exMemNext;
   exMemT  exMemOut;

   execCtrlIf ctrlBus ();

   //////////////////////////////////////////////////////////////////////
   // Decode, operands, ALU, result
   //////////////////////////////////////////////////////////////////////
   execDecode uDecode (
      .instr(instrIn), .ctrl(ctrlBus.decode), .rsValid(rsValid), .rtValid(rtValid)
   );

   // EX forward comes from the stage register's own result
   operandSelect uOperands (
      .ctrl(ctrlBus.sink), .instr(instrIn), .regA(regA), .regB(regB), .wData(wData),
      .exResult(exMemOut.result), .fwdA(fwdA), .fwdB(fwdB), .aSel(aSel), .bSel(bSel),
      .rtSel(rtSel), .ext8(ext8), .ext11(ext11)
   );

   execAlu uAlu (
      .ctrl(ctrlBus.sink), .a(aSel), .b(bSel), .y(aluOut), .zf(zf), .ofl(ofl)
   );

   resultBranch uResult (
      .ctrl(ctrlBus.sink), .instr(instrIn), .incrPc(incrPcIn), .aluOut(aluOut), .zf(zf),
      .ofl(ofl), .ext8(ext8), .ext11(ext11), .result(result), .newPc(newPc),
      .pcSrc(pcSrc), .squash(squash)
   );

   //////////////////////////////////////////////////////////////////////
   // EX/MEM payload
   //////////////////////////////////////////////////////////////////////
   assign opcode  = instrIn[15:11];
   assign isStore = (opcode == opSt) || (opcode == opStu);

   always_comb begin
      exMemNext.instr     = instrIn;
      exMemNext.result    = result;
      exMemNext.incrPc    = incrPcIn;
      // Stores carry the forwarded Rt as memory data
      exMemNext.bOut      = isStore ? rtSel : bSel;
      exMemNext.storeData = aSel;
      exMemNext.rtData    = rtSel;
      exMemNext.regWrt    = regWrtIn;
      exMemNext.unaligned = unalignedIn;
   end

   exMemReg uExMem (
      .clk(clk), .rstN(rstN), .stall(stall), .squash(squash),
      .next(exMemNext), .q(exMemOut)
   );

   assign instrOut     = exMemOut.instr;
   assign resultOut    = exMemOut.result;
   assign incrPcOut    = exMemOut.incrPc;
   assign bOut         = exMemOut.bOut;
   assign storeDataOut = exMemOut.storeData;
   assign rtDataOut    = exMemOut.rtData;
   assign regWrtOut    = exMemOut.regWrt;
   assign unalignedOut = exMemOut.unaligned;

   // Source fields for the hazard unit
   assign rsIdx = instrIn[10:8];
   assign rtIdx = instrIn[7:5];

endmodule

// ==== sim/tbExecute.sv ====
// Execute stage testbench
`timescale 1ns/1ps

module tbExecute;
   import execPkg::*;

   localparam int clkPeriod = 40;
   localparam int waitLimit = 20;

   logic    clk;
   logic    rstN;
   dataT    instrIn;
   dataT    incrPcIn;
   dataT    regA;
   dataT    regB;
   dataT    wData;
   fwdSelT  fwdA;
   fwdSelT  fwdB;
   logic    regWrtIn;
   logic    unalignedIn;
   logic    stall;
   dataT    instrOut;
   dataT    resultOut;
   dataT    incrPcOut;
   dataT    bOut;
   dataT    storeDataOut;
   dataT    rtDataOut;
   logic    regWrtOut;
   logic    unalignedOut;
   dataT    newPc;
   logic    pcSrc;
   logic    squash;
   regAddrT rsIdx;
   regAddrT rtIdx;
   logic    rsValid;
   logic    rtValid;

   integer seed;
   int     errCount;
   int     passCount;
   int     failCount;

   executeStage UUT (.*);

   initial begin
      clk = 1'b0;
      forever #(clkPeriod / 2) clk = ~clk;
   end

   //////////////////////////////////////////////////////////////////////
   // Instruction builders and ISA reference
   //////////////////////////////////////////////////////////////////////
   // Rs 1, Rt 2, Rd 3 for R-format
   function automatic dataT rFmt(input opcodeT op, input logic [1:0] fn);
      return {op, 3'd1, 3'd2, 3'd3, fn};
   endfunction

   function automatic dataT iFmt1(input opcodeT op, input logic [4:0] imm);
      return {op, 3'd1, 3'd3, imm};
   endfunction

   function automatic dataT iFmt2(input opcodeT op, input logic [7:0] imm);
      return {op, 3'd1, imm};
   endfunction

   function automatic dataT jFmt(input opcodeT op, input logic [10:0] disp);
      return {op, disp};
   endfunction

   function automatic dataT randWord();
      logic [31:0] r;
      r = $random(seed);
      return r[15:0];
   endfunction

   // Result word of one instruction from its Rs and Rt values
   function automatic dataT refAlu(input dataT instr, input dataT rs, input dataT rt);
      dataT           imm5s;
      dataT           imm5z;
      dataT           rev;
      dataT           res;
      logic [3:0]     sh;
      logic [1:0]     shKind;
      logic [dataW:0] wide;
      imm5s  = {{11{instr[4]}}, instr[4:0]};
      imm5z  = {11'h000, instr[4:0]};
      // ROL SLL ROR SRL from the function bits or the opcode
      sh     = (instr[15:11] == 5'b11010) ? rt[3:0] : instr[3:0];
      shKind = (instr[15:11] == 5'b11010) ? instr[1:0] : instr[12:11];
      wide   = {1'b0, rs} + {1'b0, rt};
      for (int i = 0; i < dataW; i++) begin
         rev[i] = rs[dataW-1-i];
      end
      case (instr[15:11])
         5'b01000: res = rs + imm5s;
         5'b01001: res = imm5s - rs;
         5'b01010: res = rs ^ imm5z;
         5'b01011: res = rs & ~imm5z;
         5'b10010: res = {rs[7:0], instr[7:0]};
         5'b10100, 5'b10101, 5'b10110, 5'b10111, 5'b11010: begin
            case (shKind)
               2'b00:   res = (rs << sh) | (rs >> (5'd16 - {1'b0, sh}));
               2'b01:   res = rs << sh;
               2'b10:   res = (rs >> sh) | (rs << (5'd16 - {1'b0, sh}));
               default: res = rs >> sh;
            endcase
         end
         5'b11000: res = {{8{instr[7]}}, instr[7:0]};
         5'b11001: res = rev;
         5'b11011: begin
            case (instr[1:0])
               2'b00:   res = rs + rt;
               2'b01:   res = rt - rs;
               2'b10:   res = rs ^ rt;
               default: res = rs & ~rt;
            endcase
         end
         5'b11100: res = {15'h0000, rs == rt};
         5'b11101: res = {15'h0000, $signed(rs) < $signed(rt)};
         5'b11110: res = {15'h0000, $signed(rs) <= $signed(rt)};
         5'b11111: res = {15'h0000, wide[dataW]};
         default:  res = '0;
      endcase
      return res;
   endfunction

   // Jumps always redirect, branches when Rs meets the condition
   function automatic logic refTaken(input dataT instr, input dataT rs);
      logic t;
      case (instr[15:11])
         5'b01100: t = (rs == '0);
         5'b01101: t = (rs != '0);
         5'b01110: t = rs[15];
         5'b01111: t = !rs[15];
         5'b00100, 5'b00101, 5'b00110, 5'b00111: t = 1'b1;
         default:  t = 1'b0;
      endcase
      return t;
   endfunction

   function automatic dataT refPc(input dataT instr, input dataT rs, input dataT pc);
      dataT imm8s;
      dataT disp;
      dataT res;
      imm8s = {{8{instr[7]}}, instr[7:0]};
      disp  = {{5{instr[10]}}, instr[10:0]};
      case (instr[15:11])
         5'b00100, 5'b00110: res = pc + disp;
         5'b00101, 5'b00111: res = rs + imm8s;
         default:            res = refTaken(instr, rs) ? pc + imm8s : pc;
      endcase
      return res;
   endfunction

   // Rs and Rt read flags from the ISA operand lists
   function automatic logic [1:0] refSrcUse(input dataT instr);
      logic rs;
      logic rt;
      case (instr[15:11])
         5'b00000, 5'b00001, 5'b00010, 5'b00011, 5'b00100, 5'b00110, 5'b11000: rs = 1'b0;
         default: rs = 1'b1;
      endcase
      case (instr[15:11])
         5'b10000, 5'b10011, 5'b11010, 5'b11011,
         5'b11100, 5'b11101, 5'b11110, 5'b11111: rt = 1'b1;
         default: rt = 1'b0;
      endcase
      return {rs, rt};
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Compare, drive and wait helpers
   //////////////////////////////////////////////////////////////////////
   task automatic checkWord(input string name, input dataT got, input dataT exp);
      if (got !== exp) begin
         $display("** Error: %s is %h, expected %h", name, got, exp);
         errCount++;
      end
   endtask

   task automatic checkBit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("** Error: %s is %h, expected %h", name, got, exp);
         errCount++;
      end
   endtask

   task automatic checkIdx(input string name, input regAddrT got, input regAddrT exp);
      if (got !== exp) begin
         $display("** Error: %s is %h, expected %h", name, got, exp);
         errCount++;
      end
   endtask

   task automatic finishTest(input string name, input int startErrs);
      if (errCount == startErrs) begin
         $display("%s: ok", name);
         passCount++;
      end else begin
         $display("%s: FAILED with %0d errors", name, errCount - startErrs);
         failCount++;
      end
   endtask

   // Hazard unit fields from the ISA field positions of the current instruction
   task automatic checkSources(input dataT instr);
      logic [1:0] srcUse;
      srcUse = refSrcUse(instr);
      checkIdx("rsIdx", rsIdx, instr[10:8]);
      checkIdx("rtIdx", rtIdx, instr[7:5]);
      checkBit("rsValid", rsValid, srcUse[1]);
      checkBit("rtValid", rtValid, srcUse[0]);
   endtask

   // Called 1 ns after an edge, so inputs change 2 ns after it
   task automatic drive(input dataT instr, input dataT a, input dataT b, input dataT pc);
      #1;
      instrIn     = instr;
      regA        = a;
      regB        = b;
      incrPcIn    = pc;
      wData       = '0;
      fwdA        = fwdNone;
      fwdB        = fwdNone;
      regWrtIn    = 1'b1;
      unalignedIn = 1'b0;
      stall       = 1'b0;
   endtask

   // Sample 1 ns after each edge until the instruction reaches the stage output
   task automatic waitOut(input dataT instr, output int cycles);
      logic seen;
      cycles = 0;
      seen   = 1'b0;
      while (!seen && cycles < waitLimit) begin
         @(posedge clk);
         #1;
         cycles++;
         seen = (instrOut == instr);
      end
      if (!seen) begin
         $display("Timed out after %0d cycles waiting for %h at instrOut", cycles, instr);
         errCount++;
      end
   endtask

   task automatic runAlu(input dataT instr, input dataT a, input dataT b);
      int cycles;
      drive(instr, a, b, 16'h0100);
      waitOut(instr, cycles);
      checkWord($sformatf("resultOut for %h", instr), resultOut, refAlu(instr, a, b));
      checkSources(instr);
   endtask

   task automatic runBranch(input dataT instr, input dataT rs);
      dataT pc;
      dataT expPc;
      logic expSquash;
      int   cycles;
      pc        = 16'h0200;
      expPc     = refPc(instr, rs, pc);
      // J and JAL never flush
      expSquash = (expPc != pc) && (instr[15:11] != 5'b00100) && (instr[15:11] != 5'b00110);
      drive(instr, rs, randWord(), pc);
      #5;
      checkWord("newPc", newPc, expPc);
      checkBit("pcSrc", pcSrc, refTaken(instr, rs));
      checkBit("squash", squash, expSquash);
      checkSources(instr);
      if (expSquash) begin
         waitOut(nopInstr, cycles);
         checkBit("regWrtOut", regWrtOut, 1'b0);
      end else begin
         waitOut(instr, cycles);
         checkBit("regWrtOut", regWrtOut, 1'b1);
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Directed tests
   //////////////////////////////////////////////////////////////////////
   task automatic testReset();
      int startErrs;
      startErrs = errCount;
      checkWord("instrOut", instrOut, nopInstr);
      checkBit("regWrtOut", regWrtOut, 1'b0);
      checkWord("resultOut", resultOut, '0);
      finishTest("Reset", startErrs);
   endtask

   task automatic testArith();
      dataT prog[16];
      dataT r;
      int   startErrs;
      startErrs = errCount;
      for (int round = 0; round < 3; round++) begin
         r        = randWord();
         prog[0]  = rFmt(5'b11011, 2'b00);
         prog[1]  = rFmt(5'b11011, 2'b01);
         prog[2]  = rFmt(5'b11011, 2'b10);
         prog[3]  = rFmt(5'b11011, 2'b11);
         prog[4]  = iFmt1(5'b01000, r[4:0]);
         prog[5]  = iFmt1(5'b01001, r[4:0]);
         prog[6]  = iFmt1(5'b01010, r[4:0]);
         prog[7]  = iFmt1(5'b01011, r[4:0]);
         // Immediate shifts and rotates
         prog[8]  = iFmt1(5'b10100, r[9:5]);
         prog[9]  = iFmt1(5'b10101, r[9:5]);
         prog[10] = iFmt1(5'b10110, r[9:5]);
         prog[11] = iFmt1(5'b10111, r[9:5]);
         prog[12] = iFmt2(5'b10010, r[15:8]);
         prog[13] = iFmt2(5'b11000, r[7:0]);
         // Register shifts and rotates, all four kinds over the rounds
         prog[14] = rFmt(5'b11010, round[1:0]);
         prog[15] = rFmt(5'b11010, 2'(round + 1));
         for (int k = 0; k < 16; k++) begin
            runAlu(prog[k], randWord(), randWord());
         end
      end
      finishTest("ALU operations", startErrs);
   endtask

   task automatic testSetCond();
      dataT aVals[7];
      dataT bVals[7];
      dataT ops[5];
      int   startErrs;
      startErrs = errCount;
      // Signed overflow pairs, carry out, equal and one random pair
      aVals = '{16'h7fff, 16'h8000, 16'hffff, 16'h1234, 16'h8000, 16'h0000, 16'h0000};
      bVals = '{16'h8000, 16'h7fff, 16'h0001, 16'h1234, 16'h8000, 16'hffff, 16'h0000};
      aVals[6] = randWord();
      bVals[6] = randWord();
      ops = '{rFmt(5'b11100, 2'b00), rFmt(5'b11101, 2'b00), rFmt(5'b11110, 2'b00),
              rFmt(5'b11111, 2'b00), iFmt1(5'b11001, 5'd0)};
      for (int p = 0; p < 7; p++) begin
         for (int k = 0; k < 5; k++) begin
            runAlu(ops[k], aVals[p], bVals[p]);
         end
      end
      finishTest("Set condition and BTR", startErrs);
   endtask

   task automatic testBranch();
      int startErrs;
      startErrs = errCount;
      runBranch(iFmt2(5'b01100, 8'h10), 16'h0000);
      runBranch(iFmt2(5'b01100, 8'h10), 16'h0005);
      runBranch(iFmt2(5'b01101, 8'h10), 16'h0005);
      runBranch(iFmt2(5'b01101, 8'h10), 16'h0000);
      runBranch(iFmt2(5'b01110, 8'hf0), 16'h8000);
      runBranch(iFmt2(5'b01110, 8'hf0), 16'h0001);
      runBranch(iFmt2(5'b01111, 8'h08), 16'h0000);
      runBranch(iFmt2(5'b01111, 8'h08), 16'hffff);
      // Taken with zero offset lands on the next PC
      runBranch(iFmt2(5'b01100, 8'h00), 16'h0000);
      runBranch(jFmt(5'b00100, 11'h040), 16'h1111);
      runBranch(jFmt(5'b00110, 11'h7f0), 16'h2222);
      runBranch(iFmt2(5'b00101, 8'h04), 16'h1000);
      runBranch(iFmt2(5'b00111, 8'h02), 16'h01fe);
      finishTest("Branches and jumps", startErrs);
   endtask

   task automatic testForward();
      dataT addI;
      dataT xorI;
      dataT subI;
      dataT w;
      dataT prev;
      int   cycles;
      int   startErrs;
      startErrs = errCount;
      addI = rFmt(5'b11011, 2'b00);
      xorI = rFmt(5'b11011, 2'b10);
      subI = rFmt(5'b11011, 2'b01);
      // Rs from writeback
      w = randWord();
      drive(addI, 16'hdead, 16'h0011, 16'h0300);
      wData = w;
      fwdA  = fwdWb;
      waitOut(addI, cycles);
      prev = refAlu(addI, w, 16'h0011);
      checkWord("resultOut", resultOut, prev);
      // Rt from the EX/MEM result of the add
      drive(xorI, 16'h5a5a, 16'hbeef, 16'h0302);
      fwdB = fwdEx;
      waitOut(xorI, cycles);
      prev = refAlu(xorI, 16'h5a5a, prev);
      checkWord("resultOut", resultOut, prev);
      // Rs from EX/MEM and Rt from writeback together
      w = randWord();
      drive(subI, 16'h0bad, 16'h0bad, 16'h0304);
      wData = w;
      fwdA  = fwdEx;
      fwdB  = fwdWb;
      waitOut(subI, cycles);
      checkWord("resultOut", resultOut, refAlu(subI, prev, w));
      finishTest("Forwarding", startErrs);
   endtask

   task automatic testStall();
      dataT first;
      dataT second;
      dataT a;
      dataT b;
      int   cycles;
      int   startErrs;
      startErrs = errCount;
      first  = rFmt(5'b11011, 2'b00);
      second = rFmt(5'b11011, 2'b11);
      a      = randWord();
      b      = randWord();
      drive(first, a, b, 16'h0400);
      waitOut(first, cycles);
      // Next instruction waits behind a memory stall
      #1;
      instrIn     = second;
      regA        = b;
      regB        = a;
      incrPcIn    = 16'h0402;
      unalignedIn = 1'b1;
      stall       = 1'b1;
      repeat (4) begin
         @(posedge clk);
         #1;
         checkWord("instrOut", instrOut, first);
         checkWord("resultOut", resultOut, refAlu(first, a, b));
         checkWord("incrPcOut", incrPcOut, 16'h0400);
         checkWord("bOut", bOut, b);
         checkWord("storeDataOut", storeDataOut, a);
         checkWord("rtDataOut", rtDataOut, b);
         checkBit("regWrtOut", regWrtOut, 1'b1);
         checkBit("unalignedOut", unalignedOut, 1'b0);
      end
      #1;
      stall = 1'b0;
      waitOut(second, cycles);
      if (cycles != 1) begin
         $display("Pending instruction took %0d edges after stall release", cycles);
         errCount++;
      end
      checkWord("resultOut", resultOut, refAlu(second, b, a));
      checkBit("unalignedOut", unalignedOut, 1'b1);
      finishTest("Stall hold", startErrs);
   endtask

   //////////////////////////////////////////////////////////////////////
   // Sequence
   //////////////////////////////////////////////////////////////////////
   initial begin
      seed        = 32'hd9920ff3;
      errCount    = 0;
      passCount   = 0;
      failCount   = 0;
      rstN        = 1'b0;
      instrIn     = nopInstr;
      incrPcIn    = '0;
      regA        = '0;
      regB        = '0;
      wData       = '0;
      fwdA        = fwdNone;
      fwdB        = fwdNone;
      regWrtIn    = 1'b0;
      unalignedIn = 1'b0;
      stall       = 1'b0;
      repeat (10) @(posedge clk);
      #1;
      testReset();
      #1;
      rstN = 1'b1;
      @(posedge clk);
      #1;
      testArith();
      testSetCond();
      testBranch();
      testForward();
      testStall();
      $display("Tests passed %0d, failed %0d", passCount, failCount);
      if (failCount == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

// ==== verilog.f ====
design/execPkg.sv
design/execCtrlIf.sv
design/execDecode.sv
design/operandSelect.sv
design/execAlu.sv
design/resultBranch.sv
design/exMemReg.sv
design/executeStage.sv
sim/tbExecute.sv

// ==== run.sh ====
#!/bin/sh
# Build the execute stage testbench with Verilator, run it and look for the pass line
verilator --binary --timing --assert -f verilog.f --top-module tbExecute -o simExecute \
   && ./obj_dir/simExecute | tee /dev/stderr | grep -q "All tests passed!" \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }
